//--- source/issue_pkg.sv
/*
 shared widths and types for the dual-issue dispatch register stage
 decode-info is carried opaquely, this stage never looks inside it
 commit ids wrap at COMMIT_ID_W bits, uniqueness is the hazard unit's job
 struct fields are packed msb first in the order listed
*/

package issue_pkg;

    // address and data widths
    localparam int INST_ADDR_W = 32;
    localparam int INST_DATA_W = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int CSR_ADDR_W  = 32;
    localparam int IMM_W       = 32;

    // opaque decode info from the decoder
    localparam int DECINFO_W   = 24;

    // reorder tracking
    localparam int COMMIT_ID_W = 4;

    typedef logic [INST_ADDR_W-1:0] inst_addr_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [CSR_ADDR_W-1:0]  csr_addr_t;
    typedef logic [COMMIT_ID_W-1:0] commit_id_t;

    // one lane of decoder output
    typedef struct packed {
        inst_addr_t             addr;
        logic                   reg_we;
        reg_addr_t              reg_waddr;
        reg_addr_t              reg1_raddr;
        reg_addr_t              reg2_raddr;
        logic                   csr_we;
        csr_addr_t              csr_waddr;
        csr_addr_t              csr_raddr;
        logic [IMM_W-1:0]       imm;
        logic [DECINFO_W-1:0]   dec_info;
        logic                   is_pred_branch;
        logic [INST_DATA_W-1:0] inst;
        logic                   illegal;
    } decoded_inst_t;

    // registered issue slot, all zero when empty
    typedef struct packed {
        logic          valid;
        commit_id_t    commit_id;
        decoded_inst_t dec;
    } issue_slot_t;

    // the two pipeline control bits this stage reads
    typedef struct packed {
        logic flush;
        logic stall_dispatch;
    } pipe_ctrl_t;

    // commit ids handed back on a jump
    typedef struct packed {
        logic       valid;
        commit_id_t commit_id1;
        commit_id_t commit_id2;
    } jump_report_t;

endpackage

//--- source/issue_lane.sv
/*
 one dispatch lane: duplicate-issue history plus the issue slot register
 slot has one cycle latency, already_issued_o is combinational
 stall holds slot and history, flush clears history even under stall
 a zero address is never treated as a duplicate
 inputs are sampled every rising clk, there is no handshake
*/

`timescale 1ns/1ps

module issue_lane
    import issue_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // from decode and the hazard unit
    input  decoded_inst_t dec_i,
    input  commit_id_t    commit_id_i,
    input  logic          issue_req_i,

    // from pipeline control
    input  pipe_ctrl_t    ctrl_i,

    output issue_slot_t   slot_o,
    output logic          already_issued_o
);

    // address seen last unstalled cycle and whether it was requested
    inst_addr_t  hist_addr;
    logic        hist_issued;

    logic        addr_nonzero;
    logic        is_dup;
    logic        suppress;
    logic        stall;

    issue_slot_t slot_nxt;
    issue_slot_t slot_q;

    assign stall        = ctrl_i.stall_dispatch;
    assign addr_nonzero = (dec_i.addr != '0);

    // same instruction still sitting here after it already went out
    assign is_dup = hist_issued && addr_nonzero && (dec_i.addr == hist_addr);

    assign suppress = ctrl_i.flush || !issue_req_i || is_dup;

    assign already_issued_o = is_dup;

    // history update
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist_addr   <= '0;
            hist_issued <= 1'b0;
        end else if (ctrl_i.flush) begin
            // flush wins over stall here
            hist_addr   <= '0;
            hist_issued <= 1'b0;
        end else if (!stall) begin
            hist_addr   <= dec_i.addr;
            hist_issued <= issue_req_i;
        end
    end

    // next slot contents, empty slot is all zero
    always_comb begin
        slot_nxt = '0;
        if (!suppress) begin
            slot_nxt.valid     = 1'b1;
            slot_nxt.commit_id = commit_id_i;
            slot_nxt.dec       = dec_i;
        end
    end

    // slot register, frozen while dispatch is stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= '0;
        end else if (!stall) begin
            slot_q <= slot_nxt;
        end
    end

    assign slot_o = slot_q;

    // stalled slot must not move, whatever flush or req do
    a_stall_holds_slot : assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable(slot_q)
    ) else $error("issue_lane: slot changed across a stalled edge");

    // unstalled flush always empties the slot
    a_flush_empties_slot : assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctrl_i.flush && !stall) |=> !slot_q.valid
    ) else $error("issue_lane: slot valid after unstalled flush");

    // a slot issued at address zero leaves a zero history behind,
    // so it can never be reported as already issued
    a_zero_addr_not_dup : assert property (
        @(posedge clk) disable iff (!rst_n)
        (slot_q.valid && (slot_q.dec.addr == '0)) |-> !already_issued_o
    ) else $error("issue_lane: zero address flagged as already issued");

endmodule

//--- source/dual_issue_stage.sv
/*
 dispatch register stage of a dual-issue in-order core
 lane 1 uses issue_req_i[0], lane 2 uses issue_req_i[1]
 slots appear one cycle after sampling, already_issued_o is same cycle
 jump report is combinational from jump_i and the registered slot ids
 and reads all zero while jump_i is low
*/

`timescale 1ns/1ps

module dual_issue_stage
    import issue_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // decoded instructions
    input  decoded_inst_t dec1_i,
    input  decoded_inst_t dec2_i,

    // from the hazard unit
    input  commit_id_t    commit_id1_i,
    input  commit_id_t    commit_id2_i,
    input  logic [1:0]    issue_req_i,

    // pipeline control and jump
    input  pipe_ctrl_t    ctrl_i,
    input  logic          jump_i,

    output issue_slot_t   slot1_o,
    output issue_slot_t   slot2_o,
    output logic [1:0]    already_issued_o,
    output jump_report_t  jump_report_o
);

    issue_slot_t slot1;
    issue_slot_t slot2;
    logic        lane1_issued;
    logic        lane2_issued;

    // older instruction of the pair
    issue_lane u_lane1 (
        .clk              (clk),
        .rst_n            (rst_n),
        .dec_i            (dec1_i),
        .commit_id_i      (commit_id1_i),
        .issue_req_i      (issue_req_i[0]),
        .ctrl_i           (ctrl_i),
        .slot_o           (slot1),
        .already_issued_o (lane1_issued)
    );

    // younger instruction of the pair
    issue_lane u_lane2 (
        .clk              (clk),
        .rst_n            (rst_n),
        .dec_i            (dec2_i),
        .commit_id_i      (commit_id2_i),
        .issue_req_i      (issue_req_i[1]),
        .ctrl_i           (ctrl_i),
        .slot_o           (slot2),
        .already_issued_o (lane2_issued)
    );

    assign slot1_o          = slot1;
    assign slot2_o          = slot2;
    assign already_issued_o = {lane2_issued, lane1_issued};

    // hand both registered ids back so the commit side can retire them
    always_comb begin
        jump_report_o = '0;
        if (jump_i) begin
            jump_report_o.valid      = 1'b1;
            jump_report_o.commit_id1 = slot1.commit_id;
            jump_report_o.commit_id2 = slot2.commit_id;
        end
    end

    // a stalled flush must not empty either slot while the
    // history of both lanes is cleared underneath
    a_stall_flush_keeps_slots : assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctrl_i.stall_dispatch && ctrl_i.flush)
            |=> ($stable(slot1) && $stable(slot2) && (already_issued_o == 2'b00))
    ) else $error("dual_issue_stage: stalled flush disturbed the slots");

endmodule

//--- sim/issue_ref_model.sv
/*
 reference model of the dispatch stage, used only by the testbench
 state moves once per rising clk from the inputs applied before it
 already-issued and jump report outputs are combinational
*/

`timescale 1ns/1ps

module issue_ref_model
    import issue_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  decoded_inst_t dec1_i,
    input  decoded_inst_t dec2_i,
    input  commit_id_t    commit_id1_i,
    input  commit_id_t    commit_id2_i,
    input  logic [1:0]    issue_req_i,
    input  pipe_ctrl_t    ctrl_i,
    input  logic          jump_i,
    output issue_slot_t   exp_slot1_o,
    output issue_slot_t   exp_slot2_o,
    output logic [1:0]    exp_issued_o,
    output jump_report_t  exp_jump_o
);

    // per lane: last address seen and whether it was requested
    inst_addr_t    seen_addr [2];
    logic          seen_req  [2];
    issue_slot_t   slot      [2];
    decoded_inst_t lane_dec  [2];
    commit_id_t    lane_cid  [2];
    logic [1:0]    dup;

    // held at a nonzero address after it already went out
    function automatic logic held_after_issue(input inst_addr_t addr,
                                              input inst_addr_t last_addr,
                                              input logic       last_req);
        return last_req && (addr != '0) && (addr == last_addr);
    endfunction

    function automatic issue_slot_t slot_for(input decoded_inst_t d,
                                             input commit_id_t    cid,
                                             input logic          req,
                                             input logic          is_dup,
                                             input logic          flush);
        issue_slot_t s;
        s = '0;
        if (req && !is_dup && !flush) begin
            s.valid     = 1'b1;
            s.commit_id = cid;
            s.dec       = d;
        end
        return s;
    endfunction

    always_comb begin
        lane_dec[0] = dec1_i;
        lane_dec[1] = dec2_i;
        lane_cid[0] = commit_id1_i;
        lane_cid[1] = commit_id2_i;
    end

    assign dup[0] = held_after_issue(dec1_i.addr, seen_addr[0], seen_req[0]);
    assign dup[1] = held_after_issue(dec2_i.addr, seen_addr[1], seen_req[1]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < 2; l++) begin
                seen_addr[l] <= '0;
                seen_req[l]  <= 1'b0;
                slot[l]      <= '0;
            end
        end else begin
            for (int l = 0; l < 2; l++) begin
                if (!ctrl_i.stall_dispatch) begin
                    slot[l] <= slot_for(lane_dec[l], lane_cid[l], issue_req_i[l],
                                        dup[l], ctrl_i.flush);
                end
                // history forgets on flush even while stalled
                if (ctrl_i.flush) begin
                    seen_addr[l] <= '0;
                    seen_req[l]  <= 1'b0;
                end else if (!ctrl_i.stall_dispatch) begin
                    seen_addr[l] <= lane_dec[l].addr;
                    seen_req[l]  <= issue_req_i[l];
                end
            end
        end
    end

    assign exp_slot1_o  = slot[0];
    assign exp_slot2_o  = slot[1];
    assign exp_issued_o = dup;

    always_comb begin
        exp_jump_o = '0;
        if (jump_i) begin
            exp_jump_o.valid      = 1'b1;
            exp_jump_o.commit_id1 = slot[0].commit_id;
            exp_jump_o.commit_id2 = slot[1].commit_id;
        end
    end

endmodule

//--- sim/tb_dual_issue_stage.sv
/*
 random testbench for the dual-issue dispatch stage
 inputs change on the falling edge
 outputs are compared on the next falling edge against issue_ref_model
 addresses come from a four entry pool that includes zero
 stops at the first mismatch
*/

`timescale 1ns/1ps

module tb_dual_issue_stage
    import issue_pkg::*;
();

    localparam logic [31:0] SEED         = 32'h2faebd19;
    localparam int          NUM_CYCLES   = 3000;
    localparam int          SLOT_TIMEOUT = 20;

    logic          clk;
    logic          rst_n;
    decoded_inst_t dec1;
    decoded_inst_t dec2;
    commit_id_t    commit_id1;
    commit_id_t    commit_id2;
    logic [1:0]    issue_req;
    pipe_ctrl_t    ctrl;
    logic          jump;

    issue_slot_t   slot1;
    issue_slot_t   slot2;
    logic [1:0]    already_issued;
    jump_report_t  jump_report;

    issue_slot_t   exp_slot1;
    issue_slot_t   exp_slot2;
    logic [1:0]    exp_issued;
    jump_report_t  exp_jump;

    logic [31:0]   rng_state;
    int            dup_seen;
    int            stall_flush_seen;
    int            jump_seen;

    dual_issue_stage u_dual_issue_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .dec1_i           (dec1),
        .dec2_i           (dec2),
        .commit_id1_i     (commit_id1),
        .commit_id2_i     (commit_id2),
        .issue_req_i      (issue_req),
        .ctrl_i           (ctrl),
        .jump_i           (jump),
        .slot1_o          (slot1),
        .slot2_o          (slot2),
        .already_issued_o (already_issued),
        .jump_report_o    (jump_report)
    );

    issue_ref_model u_ref_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec1_i       (dec1),
        .dec2_i       (dec2),
        .commit_id1_i (commit_id1),
        .commit_id2_i (commit_id2),
        .issue_req_i  (issue_req),
        .ctrl_i       (ctrl),
        .jump_i       (jump),
        .exp_slot1_o  (exp_slot1),
        .exp_slot2_o  (exp_slot2),
        .exp_issued_o (exp_issued),
        .exp_jump_o   (exp_jump)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // small pool so the same address comes back often
    function automatic inst_addr_t pool_addr(input logic [1:0] pick);
        case (pick)
            2'd0:    return '0;
            2'd1:    return 32'h0000_1000;
            2'd2:    return 32'h0000_1004;
            default: return 32'h8000_0040;
        endcase
    endfunction

    task automatic random_dec(input logic [1:0] pick, output decoded_inst_t d);
        logic [223:0] bits;
        logic [31:0]  r;
        for (int i = 0; i < 7; i++) begin
            next_rand(r);
            bits[i*32 +: 32] = r;
        end
        d = decoded_inst_t'(bits[$bits(decoded_inst_t)-1:0]);
        d.addr = pool_addr(pick);
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run("DUT output differs from the reference model");
        end
    endtask

    task automatic compare_outputs();
        check_value("slot1_o", 256'(slot1), 256'(exp_slot1));
        check_value("slot2_o", 256'(slot2), 256'(exp_slot2));
        check_value("already_issued_o", 256'(already_issued), 256'(exp_issued));
        check_value("jump_report_o", 256'(jump_report), 256'(exp_jump));
    endtask

    // wait one falling edge and check what the last edge did
    task automatic step();
        @(negedge clk);
        compare_outputs();
        if (already_issued != 2'b00) begin
            dup_seen++;
        end
        if (jump && (slot1.valid || slot2.valid)) begin
            jump_seen++;
        end
    endtask

    task automatic wait_both_slots_valid(input int max_cycles);
        int waited;
        waited = 0;
        while (!(slot1.valid && slot2.valid) && (waited < max_cycles)) begin
            step();
            waited++;
        end
        if (!(slot1.valid && slot2.valid)) begin
            abort_run("timed out waiting for both issue slots to fill after reset");
        end
    endtask

    // flush, stall and jump are rare
    // each lane keeps its instruction half the time
    task automatic drive_random();
        logic [31:0]   r;
        decoded_inst_t d;
        next_rand(r);
        if (r[0]) begin
            random_dec(r[21:20], d);
            dec1 = d;
        end
        if (r[1]) begin
            random_dec(r[23:22], d);
            dec2 = d;
        end
        issue_req[0]        = (r[3:2] != 2'b00);
        issue_req[1]        = (r[5:4] != 2'b00);
        ctrl.flush          = (r[9:6] == 4'h0);
        ctrl.stall_dispatch = (r[12:10] == 3'h0);
        jump                = (r[15:13] == 3'h0);
        commit_id1          = r[27:24];
        commit_id2          = r[31:28];
        if (ctrl.flush && ctrl.stall_dispatch) begin
            stall_flush_seen++;
        end
    endtask

    initial begin
        rng_state        = SEED;
        rst_n            = 1'b0;
        dec1             = '0;
        dec2             = '0;
        commit_id1       = '0;
        commit_id2       = '0;
        issue_req        = 2'b00;
        ctrl             = '0;
        jump             = 1'b0;
        dup_seen         = 0;
        stall_flush_seen = 0;
        jump_seen        = 0;

        repeat (5) @(negedge clk);
        // empty slots, no flags and no jump report out of reset
        compare_outputs();
        rst_n = 1'b1;

        // first pair is requested on both lanes
        random_dec(2'd1, dec1);
        random_dec(2'd2, dec2);
        commit_id1 = 4'd1;
        commit_id2 = 4'd2;
        issue_req  = 2'b11;
        wait_both_slots_valid(SLOT_TIMEOUT);

        for (int i = 0; i < NUM_CYCLES; i++) begin
            drive_random();
            step();
        end

        if ((dup_seen > 0) && (stall_flush_seen > 0) && (jump_seen > 0)) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("random run missed duplicates, stalled flushes or jumps");
        end
    end

endmodule

//--- verilog.f
source/issue_pkg.sv
source/issue_lane.sv
source/dual_issue_stage.sv
sim/issue_ref_model.sv
sim/tb_dual_issue_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the dispatch stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f verilog.f --top-module tb_dual_issue_stage -o tb_dual_issue_stage \
    && ./obj_dir/tb_dual_issue_stage | tee /dev/stderr | grep "TESTS PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
